//--- hw/wb_consts.svh
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// RV64 datapath width
`define WB_XLEN 64

// register index width and register count
`define WB_REG_ADDR_W 5
`define WB_NUM_GPR 32

// one strobe bit per data byte
`define WB_STRB_W 8

// APB address width
// addresses above this width are dropped at the bus
`define WB_PADDR_W 32

`endif

//--- hw/wb_pkg.sv
`include "wb_consts.svh"

package wb_pkg;

    // operation carried by an incoming instruction
    // loads first, then stores, so range checks stay simple
    typedef enum logic [3:0] {
        op_none,
        op_alu,
        op_lb,
        op_lh,
        op_lw,
        op_ld,
        op_lbu,
        op_lhu,
        op_lwu,
        op_sb,
        op_sh,
        op_sw,
        op_sd
    } mem_op_e;

    // controller states
    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access,
        st_commit
    } lsu_state_e;

    // one finished instruction from the execute side
    typedef struct packed {
        mem_op_e                    op;
        logic [`WB_REG_ADDR_W-1:0]  rd;
        logic [`WB_XLEN-1:0]        addr;
        logic [`WB_XLEN-1:0]        sdata;
        logic [`WB_XLEN-1:0]        result;
    } wb_req_t;

    // one retirement, also the register write port
    typedef struct packed {
        logic                       valid;
        logic                       wen;
        logic [`WB_REG_ADDR_W-1:0]  rd;
        logic [`WB_XLEN-1:0]        wdata;
    } wb_commit_t;

endpackage

//--- hw/store_align.sv
`timescale 1ns/1ns
`include "wb_consts.svh"

module store_align (
    input  wb_pkg::mem_op_e         op,
    input  logic [2:0]              offset,
    input  logic [`WB_XLEN-1:0]     sdata,
    output logic [`WB_XLEN-1:0]     wdata,
    output logic [`WB_STRB_W-1:0]   strb
);
    import wb_pkg::*;

    // byte offset turned into a bit shift
    logic [5:0] shamt;

    assign shamt = {offset, 3'b000};

    always_comb begin
        // loads, alu and bubbles write nothing
        wdata = '0;
        strb  = '0;
        case (op)
            op_sb: begin
                wdata = {56'b0, sdata[7:0]} << shamt;
                strb  = 8'h01 << offset;
            end
            op_sh: begin
                // offset is even here, so the pair never wraps
                wdata = {48'b0, sdata[15:0]} << shamt;
                strb  = 8'h03 << offset;
            end
            op_sw: begin
                // offset is 0 or 4
                wdata = {32'b0, sdata[31:0]} << shamt;
                strb  = 8'h0f << offset;
            end
            op_sd: begin
                // whole doubleword, offset is zero
                wdata = sdata;
                strb  = 8'hff;
            end
            default: begin
                wdata = '0;
                strb  = '0;
            end
        endcase
    end

endmodule

//--- hw/load_extract.sv
`timescale 1ns/1ns
`include "wb_consts.svh"

module load_extract (
    input  wb_pkg::mem_op_e         op,
    input  logic [2:0]              offset,
    input  logic [`WB_XLEN-1:0]     rdata,
    output logic [`WB_XLEN-1:0]     value
);
    import wb_pkg::*;

    logic [5:0]             shamt;
    logic [`WB_XLEN-1:0]    shifted;

    // addressed byte moved down to lane 0
    assign shamt   = {offset, 3'b000};
    assign shifted = rdata >> shamt;

    always_comb begin
        case (op)
            // signed loads
            op_lb: begin
                value = {{56{shifted[7]}}, shifted[7:0]};
            end
            op_lh: begin
                value = {{48{shifted[15]}}, shifted[15:0]};
            end
            op_lw: begin
                value = {{32{shifted[31]}}, shifted[31:0]};
            end
            // doubleword is always at offset zero
            op_ld: begin
                value = rdata;
            end
            // unsigned loads
            op_lbu: begin
                value = {56'b0, shifted[7:0]};
            end
            op_lhu: begin
                value = {48'b0, shifted[15:0]};
            end
            op_lwu: begin
                value = {32'b0, shifted[31:0]};
            end
            // stores and non-memory ops carry no load data
            default: begin
                value = '0;
            end
        endcase
    end

endmodule

//--- hw/lsu_ctrl.sv
`timescale 1ns/1ns
`include "wb_consts.svh"

module lsu_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  wb_pkg::wb_req_t         req,
    output logic                    psel,
    output logic                    penable,
    output logic                    pwrite,
    output logic [`WB_PADDR_W-1:0]  paddr,
    output logic [`WB_XLEN-1:0]     pwdata,
    output logic [`WB_STRB_W-1:0]   pstrb,
    input  logic [`WB_XLEN-1:0]     prdata,
    input  logic                    pready,
    output wb_pkg::wb_commit_t      commit
);
    import wb_pkg::*;

    lsu_state_e             state;
    lsu_state_e             state_nxt;
    wb_req_t                req_q;
    logic                   accept;
    logic                   req_is_mem;
    logic                   held_is_load;
    logic                   held_is_store;
    logic                   xfer_done;
    logic [`WB_XLEN-1:0]    load_value;

    function automatic logic is_load(mem_op_e op);
        return op inside {op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {op_sb, op_sh, op_sw, op_sd};
    endfunction

    // natural alignment by access size
    function automatic logic is_aligned(mem_op_e op, logic [2:0] lo);
        case (op)
            op_lh, op_lhu, op_sh: return lo[0] == 1'b0;
            op_lw, op_lwu, op_sw: return lo[1:0] == 2'b00;
            op_ld, op_sd:         return lo == 3'b000;
            default:              return 1'b1;
        endcase
    endfunction

    // single issue, only idle takes a new request
    assign req_ready     = (state == st_idle);
    assign accept        = req_valid && req_ready;
    assign req_is_mem    = is_load(req.op) || is_store(req.op);
    assign held_is_load  = is_load(req_q.op);
    assign held_is_store = is_store(req_q.op);
    assign xfer_done     = (state == st_access) && pready;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                // alu and bubbles skip the bus
                if (accept) begin
                    state_nxt = req_is_mem ? st_setup : st_commit;
                end
            end
            st_setup:  state_nxt = st_access;
            st_access: begin
                if (pready) begin
                    state_nxt = st_commit;
                end
            end
            st_commit: state_nxt = st_idle;
            default:   state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // held copy of the accepted instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // commit is loaded on the edge that enters st_commit
    always_ff @(posedge clk) begin
        if (rst) begin
            commit <= '0;
        end else begin
            commit.valid <= 1'b0;
            if (accept && !req_is_mem) begin
                commit.valid <= 1'b1;
                commit.wen   <= (req.op == op_alu);
                commit.rd    <= req.rd;
                commit.wdata <= req.result;
            end else if (xfer_done) begin
                // load value sampled with pready, stores give zero here
                commit.valid <= 1'b1;
                commit.wen   <= held_is_load;
                commit.rd    <= req_q.rd;
                commit.wdata <= load_value;
            end
        end
    end

    // APB master side
    assign psel    = (state == st_setup) || (state == st_access);
    assign penable = (state == st_access);
    assign pwrite  = psel && held_is_store;
    assign paddr   = {req_q.addr[`WB_PADDR_W-1:3], 3'b000};

    store_align u_store_align (
        .op     (req_q.op),
        .offset (req_q.addr[2:0]),
        .sdata  (req_q.sdata),
        .wdata  (pwdata),
        .strb   (pstrb)
    );

    load_extract u_load_extract (
        .op     (req_q.op),
        .offset (req_q.addr[2:0]),
        .rdata  (prdata),
        .value  (load_value)
    );

    // a started transfer holds psel until the slave completes it
    a_psel_hold: assert property (@(posedge clk) disable iff (rst)
        psel && !(penable && pready) |=> psel);

    a_paddr_stable: assert property (@(posedge clk) disable iff (rst)
        psel && !(penable && pready) |=> $stable(paddr));

    // upstream only sends naturally aligned memory accesses
    a_req_aligned: assert property (@(posedge clk) disable iff (rst)
        accept && req_is_mem |-> is_aligned(req.op, req.addr[2:0]));

endmodule

//--- hw/retire_counter.sv
`timescale 1ns/1ns
`include "wb_consts.svh"

module retire_counter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    commit_valid,
    output logic [`WB_XLEN-1:0]     instret
);

    // one step per retirement, bubbles included
    always_ff @(posedge clk) begin
        if (rst) begin
            instret <= '0;
        end else if (commit_valid) begin
            instret <= instret + 1'b1;
        end
    end

endmodule

//--- hw/gpr_file.sv
`timescale 1ns/1ns
`include "wb_consts.svh"

module gpr_file (
    input  logic                        clk,
    input  logic                        rst,
    input  wb_pkg::wb_commit_t          commit,
    input  logic [`WB_REG_ADDR_W-1:0]   rs_addr,
    output logic [`WB_XLEN-1:0]         rs_data
);

    logic [`WB_XLEN-1:0]    regs [`WB_NUM_GPR];
    logic                   we;

    // x0 is never a write target
    assign we = commit.valid && commit.wen && (commit.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `WB_NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[commit.rd] <= commit.wdata;
        end
    end

    // combinational read, x0 forced to zero
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];

    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        regs[0] == '0);

endmodule

//--- hw/wb_stage.sv
`timescale 1ns/1ns
`include "wb_consts.svh"

module wb_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_valid,
    output logic                        req_ready,
    input  wb_pkg::wb_req_t             req,
    output logic                        psel,
    output logic                        penable,
    output logic                        pwrite,
    output logic [`WB_PADDR_W-1:0]      paddr,
    output logic [`WB_XLEN-1:0]         pwdata,
    output logic [`WB_STRB_W-1:0]       pstrb,
    input  logic [`WB_XLEN-1:0]         prdata,
    input  logic                        pready,
    output wb_pkg::wb_commit_t          commit,
    output logic [`WB_XLEN-1:0]         instret,
    input  logic [`WB_REG_ADDR_W-1:0]   rs_addr,
    output logic [`WB_XLEN-1:0]         rs_data
);

    // request handshake, APB master and commit source
    lsu_ctrl u_lsu_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .prdata     (prdata),
        .pready     (pready),
        .commit     (commit)
    );

    // every commit counts, with or without a register write
    retire_counter u_retire_counter (
        .clk            (clk),
        .rst            (rst),
        .commit_valid   (commit.valid),
        .instret        (instret)
    );

    // commit doubles as the register write port
    gpr_file u_gpr_file (
        .clk        (clk),
        .rst        (rst),
        .commit     (commit),
        .rs_addr    (rs_addr),
        .rs_data    (rs_data)
    );

endmodule

//--- tb/apb_mem_model.sv
`timescale 1ns/1ns
`include "wb_consts.svh"

module apb_mem_model (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`WB_PADDR_W-1:0]  paddr,
    input  logic [`WB_XLEN-1:0]     pwdata,
    input  logic [`WB_STRB_W-1:0]   pstrb,
    output logic [`WB_XLEN-1:0]     prdata,
    output logic                    pready
);

    // 32 doublewords, filled by the testbench before reset ends
    logic [`WB_XLEN-1:0]    mem [32];
    logic [15:0]            lfsr;
    logic [1:0]             wait_cnt;

    // galois lfsr, returns the bit shifted out
    function automatic logic step_lfsr();
        logic out;
        out  = lfsr[0];
        lfsr = {1'b0, lfsr[15:1]} ^ (out ? 16'hb400 : 16'h0000);
        return out;
    endfunction

    // doubleword index from paddr, no decode above it
    assign prdata = mem[paddr[7:3]];
    assign pready = psel && penable && (wait_cnt == 2'd0);

    always @(posedge clk) begin
        logic hi;
        logic lo;
        if (rst) begin
            lfsr     = 16'd12548;
            wait_cnt <= '0;
        end else if (psel && !penable) begin
            // setup phase picks 0 to 3 wait states
            hi = step_lfsr();
            lo = step_lfsr();
            wait_cnt <= {hi, lo};
        end else if (psel && penable && wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end else if (pready && pwrite) begin
            // only strobed lanes change
            for (int b = 0; b < 8; b++) begin
                if (pstrb[b]) begin
                    mem[paddr[7:3]][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- tb/tb_wb_stage.sv
`timescale 1ns/1ns
`include "wb_consts.svh"

module tb_wb_stage;
    import wb_pkg::*;

    localparam int NUM_REQS    = 200;
    localparam int CYCLE_LIMIT = NUM_REQS * 8 + 100;

    logic                           clk = 1'b0;
    logic                           rst;
    logic                           req_valid;
    logic                           req_ready;
    wb_req_t                        req;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [`WB_PADDR_W-1:0]         paddr;
    logic [`WB_XLEN-1:0]            pwdata;
    logic [`WB_STRB_W-1:0]          pstrb;
    logic [`WB_XLEN-1:0]            prdata;
    logic                           pready;
    wb_commit_t                     commit;
    logic [`WB_XLEN-1:0]            instret;
    logic [`WB_REG_ADDR_W-1:0]      rs_addr;
    logic [`WB_XLEN-1:0]            rs_data;

    // reference model state
    logic [15:0]            lfsr = 16'd12548;
    logic [`WB_XLEN-1:0]    shadow_mem [32];
    logic [`WB_XLEN-1:0]    shadow_reg [`WB_NUM_GPR];
    wb_req_t                held;
    logic                   in_flight;
    logic [`WB_XLEN-1:0]    accepted;
    logic [`WB_XLEN-1:0]    exp_instret;
    logic                   acc;
    logic                   req_mem;
    logic                   held_store;
    logic [31:0]            exp_paddr;
    logic [7:0]             exp_pstrb;
    logic [63:0]            exp_pwdata;
    logic                   exp_wen;
    logic [63:0]            exp_wdata;
    logic [63:0]            exp_rs;
    int                     issued = 0;
    int                     cycles = 0;
    int                     value_errors = 0;
    int                     protocol_errors = 0;

    always #4 clk = ~clk;

    wb_stage dut (.*);
    apb_mem_model mem_model (.*);

    // galois lfsr, one step per bit handed out
    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[62:0], lfsr[0]};
            lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
        end
        return r;
    endfunction

    function automatic int access_bytes(mem_op_e op);
        case (op)
            op_lb, op_lbu, op_sb: return 1;
            op_lh, op_lhu, op_sh: return 2;
            op_lw, op_lwu, op_sw: return 4;
            default:              return 8;
        endcase
    endfunction

    // one strobe bit per byte the store covers
    function automatic logic [7:0] store_strobe(mem_op_e op, logic [2:0] off);
        logic [7:0] s;
        s = '0;
        for (int b = 0; b < 8; b++) begin
            s[b] = (op >= op_sb) && (b >= off) && (b < off + access_bytes(op));
        end
        return s;
    endfunction

    function automatic logic [63:0] store_lanes(mem_op_e op, logic [2:0] off,
                                                logic [63:0] sdata);
        logic [63:0] d;
        logic [7:0]  s;
        d = '0;
        s = store_strobe(op, off);
        // source byte 0 lands on lane off
        for (int b = 0; b < 8; b++) begin
            if (s[b]) begin
                d[8*b +: 8] = sdata[8*(b - off) +: 8];
            end
        end
        return d;
    endfunction

    function automatic logic [63:0] load_value(mem_op_e op, logic [2:0] off, logic [63:0] dw);
        logic [63:0] v;
        int          n;
        n = access_bytes(op);
        v = '0;
        for (int b = 0; b < n; b++) begin
            v[8*b +: 8] = dw[8*(off + b) +: 8];
        end
        // signed loads copy the top loaded bit upward
        if (op inside {op_lb, op_lh, op_lw}) begin
            for (int i = 8 * n; i < 64; i++) begin
                v[i] = v[8 * n - 1];
            end
        end
        return v;
    endfunction

    task automatic report_value(string name, logic [63:0] got, logic [63:0] exp);
        value_errors++;
        $display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    endtask

    task automatic report_protocol(string msg);
        protocol_errors++;
        $display("%s at %0t", msg, $time);
    endtask

    // hold the request until accepted, then wait for its commit
    task automatic issue(mem_op_e op, logic [4:0] rd, logic [63:0] addr,
                         logic [63:0] sdata, logic [63:0] result);
        req.op     = op;
        req.rd     = rd;
        req.addr   = addr;
        req.sdata  = sdata;
        req.result = result;
        req_valid  = 1'b1;
        while (!req_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        req_valid = 1'b0;
        while (!commit.valid) begin
            @(negedge clk);
        end
        // keep the written register on the read port
        rs_addr = rd;
        issued++;
    endtask

    task automatic issue_random();
        mem_op_e     op;
        logic [2:0]  off;
        logic [4:0]  rd;
        logic [4:0]  idx;
        logic [63:0] data;
        op   = mem_op_e'(4'(rand_bits(4) % 13));
        off  = 3'(rand_bits(3));
        rd   = 5'(rand_bits(5));
        idx  = 5'(rand_bits(5));
        data = rand_bits(64);
        // clear offset bits below the access size
        off = off & ~3'(access_bytes(op) - 1);
        issue(op, rd, {56'b0, idx, off}, data, data);
    endtask

    assign acc        = req_valid && req_ready;
    assign req_mem    = (req.op >= op_lb);
    assign held_store = (held.op >= op_sb);
    assign exp_paddr  = {held.addr[31:3], 3'b000};
    assign exp_pstrb  = store_strobe(held.op, held.addr[2:0]);
    assign exp_pwdata = store_lanes(held.op, held.addr[2:0], held.sdata);
    assign exp_wen    = (held.op != op_none) && !held_store;
    assign exp_wdata  = (held.op == op_alu) ? held.result
                        : load_value(held.op, held.addr[2:0], shadow_mem[held.addr[7:3]]);
    assign exp_rs     = (rs_addr == '0) ? '0 : shadow_reg[rs_addr];
    // every accepted request retires, the one in flight not yet
    assign exp_instret = accepted - in_flight;

    // shadow registers and memory follow each commit
    always @(posedge clk) begin
        if (rst) begin
            in_flight <= 1'b0;
            accepted  <= '0;
            for (int r = 0; r < `WB_NUM_GPR; r++) begin
                shadow_reg[r] <= '0;
            end
        end else begin
            if (acc) begin
                held      <= req;
                in_flight <= 1'b1;
                accepted  <= accepted + 1'b1;
            end
            if (commit.valid) begin
                in_flight <= 1'b0;
                if (exp_wen && held.rd != '0) begin
                    shadow_reg[held.rd] <= exp_wdata;
                end
                for (int b = 0; b < 8; b++) begin
                    if (held_store && exp_pstrb[b]) begin
                        shadow_mem[held.addr[7:3]][8*b +: 8] <= exp_pwdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // handshake and APB sequencing
    a_ready_busy: assert property (@(posedge clk) disable iff (rst) in_flight |-> !req_ready)
        else report_protocol("req_ready was high while a request was in flight");
    a_ready_idle: assert property (@(posedge clk) disable iff (rst) !in_flight |-> req_ready)
        else report_protocol("req_ready stayed low with no request in flight");
    a_alu_latency: assert property (@(posedge clk) disable iff (rst)
        acc && !req_mem |=> commit.valid)
        else report_protocol("no commit one cycle after a non-memory request was accepted");
    a_setup: assert property (@(posedge clk) disable iff (rst) acc && req_mem |=> psel && !penable)
        else report_protocol("setup phase did not follow a memory request");
    a_access: assert property (@(posedge clk) disable iff (rst) psel && !penable |=> penable)
        else report_protocol("access phase did not follow the setup phase");
    a_psel_hold: assert property (@(posedge clk) disable iff (rst)
        psel && penable && !pready |=> psel && penable && $stable(paddr))
        else report_protocol("psel, penable or paddr changed before pready");
    a_xfer_commit: assert property (@(posedge clk) disable iff (rst)
        psel && penable && pready |=> commit.valid)
        else report_protocol("no commit in the cycle after pready");
    a_commit_src: assert property (@(posedge clk) disable iff (rst) commit.valid |-> in_flight)
        else report_protocol("commit seen with no request in flight");

    // values against the reference model
    a_paddr: assert property (@(posedge clk) disable iff (rst) psel |-> paddr == exp_paddr)
        else report_value("paddr", $sampled(paddr), $sampled(exp_paddr));
    a_pwrite: assert property (@(posedge clk) disable iff (rst) psel |-> pwrite == held_store)
        else report_value("pwrite", $sampled(pwrite), $sampled(held_store));
    a_pstrb: assert property (@(posedge clk) disable iff (rst) psel |-> pstrb == exp_pstrb)
        else report_value("pstrb", $sampled(pstrb), $sampled(exp_pstrb));
    a_pwdata: assert property (@(posedge clk) disable iff (rst)
        psel && pwrite |-> pwdata == exp_pwdata)
        else report_value("pwdata", $sampled(pwdata), $sampled(exp_pwdata));
    a_commit_wen: assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> commit.wen == exp_wen)
        else report_value("commit.wen", $sampled(commit.wen), $sampled(exp_wen));
    a_commit_rd: assert property (@(posedge clk) disable iff (rst)
        commit.valid && commit.wen |-> commit.rd == held.rd)
        else report_value("commit.rd", $sampled(commit.rd), $sampled(held.rd));
    a_commit_wdata: assert property (@(posedge clk) disable iff (rst)
        commit.valid && commit.wen |-> commit.wdata == exp_wdata)
        else report_value("commit.wdata", $sampled(commit.wdata), $sampled(exp_wdata));
    a_rs_data: assert property (@(posedge clk) disable iff (rst) rs_data == exp_rs)
        else report_value("rs_data", $sampled(rs_data), $sampled(exp_rs));
    a_instret: assert property (@(posedge clk) disable iff (rst) instret == exp_instret)
        else report_value("instret", $sampled(instret), $sampled(exp_instret));

    initial begin
        logic [4:0]  rd;
        logic [4:0]  idx;
        logic [63:0] data;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rs_addr   = '0;
        // same random contents in the model and the shadow copy
        for (int i = 0; i < 32; i++) begin
            data               = rand_bits(64);
            shadow_mem[i]      = data;
            mem_model.mem[i]   = data;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (req_ready && !psel && !commit.valid)
            else report_protocol("handshake or APB outputs not idle after reset");
        assert (instret == '0) else report_value("instret", instret, '0);
        for (int i = 0; i < `WB_NUM_GPR; i++) begin
            rs_addr = 5'(i);
            @(negedge clk);
            assert (rs_data == '0) else report_value("rs_data", rs_data, '0);
        end
        // alu writebacks, the first one aimed at x0
        for (int i = 0; i < 8; i++) begin
            rd   = (i == 0) ? 5'd0 : 5'(rand_bits(5));
            data = rand_bits(64);
            issue(op_alu, rd, '0, '0, data);
        end
        issue(op_none, 5'd3, '0, '0, rand_bits(64));
        issue(op_none, 5'd0, '0, '0, rand_bits(64));
        // each store width at each offset, then read the doubleword back
        for (int k = op_sb; k <= op_sd; k++) begin
            for (int off = 0; off < 8; off += access_bytes(mem_op_e'(k))) begin
                rd   = 5'(rand_bits(5));
                idx  = 5'(rand_bits(5));
                data = rand_bits(64);
                issue(mem_op_e'(k), rd, {56'b0, idx, 3'(off)}, data, '0);
                issue(op_ld, rd, {56'b0, idx, 3'b000}, '0, '0);
            end
        end
        // each load width and sign at each offset
        for (int k = op_lb; k <= op_lwu; k++) begin
            for (int off = 0; off < 8; off += access_bytes(mem_op_e'(k))) begin
                rd  = 5'(rand_bits(5));
                idx = 5'(rand_bits(5));
                issue(mem_op_e'(k), rd, {56'b0, idx, 3'(off)}, '0, '0);
            end
        end
        while (issued < NUM_REQS) begin
            issue_random();
        end
        // last commit reaches instret on the next edge
        @(negedge clk);
        assert (instret == 64'(issued)) else report_value("instret", instret, 64'(issued));
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- wb_stage.f
+incdir+hw
hw/wb_pkg.sv
hw/store_align.sv
hw/load_extract.sv
hw/lsu_ctrl.sv
hw/retire_counter.sv
hw/gpr_file.sv
hw/wb_stage.sv
tb/apb_mem_model.sv
tb/tb_wb_stage.sv
